// File: logic/piArbiter.sv
`timescale 1ns/100ps

module piArbiter (
  input  logic               clk,
  input  logic               TIM,
  input  pi_pkg::piLevelVecT ioReq,
  input  logic               aprInt,
  input  logic               mtrInt,
  input  pi_pkg::piLevelT    aprChannel,
  input  pi_pkg::piLevelT    mtrChannel,
  input  pi_pkg::piLevelVecT levelOn,
  input  pi_pkg::piLevelVecT softReq,
  input  logic               sysActive,
  input  logic               intAck,
  input  logic               dismiss,
  input  logic               cycleBusy,
  output logic               intReq,
  output pi_pkg::piLevelT    intLevel,
  output pi_pkg::piLevelVecT held
);
  import pi_pkg::*;

  piLevelVecT aprBit;
  piLevelVecT mtrBit;
  piLevelVecT pendNow;
  piLevelVecT reqReg;
  piLevelVecT ackBit;
  piLevelVecT dismissBit;
  piLevelT pendLevel;
  piLevelT holdLevel;
  logic eligible;
  logic ack;
  logic keepOffer;

  // Channel 0 leaves a source disconnected
  assign aprBit = aprInt ? levelBit(aprChannel) : '0;
  assign mtrBit = mtrInt ? levelBit(mtrChannel) : '0;

  // Software requests skip the level enable
  assign pendNow = sysActive ? (softReq | (levelOn & (ioReq | aprBit | mtrBit))) : '0;

  always_ff @(posedge clk or posedge TIM) begin
    if (TIM) begin
      reqReg <= '0;
    end else begin
      reqReg <= pendNow;
    end
  end

  assign pendLevel = lowestLevel(reqReg);
  assign holdLevel = lowestLevel(held);

  // Must strictly outrank the highest held level
  assign eligible = (pendLevel != '0) && ((holdLevel == '0) || (pendLevel < holdLevel));

  assign ack = intReq & intAck;
  assign keepOffer = |(reqReg & levelBit(intLevel));  // Offered level still requesting

  always_ff @(posedge clk or posedge TIM) begin
    if (TIM) begin
      intReq <= 1'b0;
      intLevel <= '0;
    end else if (ack) begin
      intReq <= 1'b0;
    end else if (intReq) begin
      intReq <= keepOffer;  // intLevel frozen while offered
    end else begin
      intReq <= eligible & ~cycleBusy;
      intLevel <= eligible ? pendLevel : '0;
    end
  end

  assign ackBit = ack ? levelBit(intLevel) : '0;
  assign dismissBit = dismiss ? levelBit(holdLevel) : '0;

  always_ff @(posedge clk or posedge TIM) begin
    if (TIM) begin
      held <= '0;
    end else begin
      held <= (held & ~dismissBit) | ackBit;
    end
  end

endmodule

// File: logic/piCtl.sv
`timescale 1ns/100ps

module piCtl (
  input  logic               clk,
  input  logic               TIM,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [4:0]         paddr,
  input  logic [31:0]        pwdata,
  output logic [31:0]        prdata,
  output logic               pready,
  output logic               pslverr,
  input  pi_pkg::piLevelVecT ioReq,
  input  logic               aprInt,
  input  logic               mtrInt,
  output logic               intReq,
  output pi_pkg::piLevelT    intLevel,
  input  logic               intAck,
  input  logic               dismiss,
  output logic               vecDone,
  output pi_pkg::piVectorT   vecOut,
  output logic               vecReq,
  output pi_pkg::piLevelT    vecLevel,
  input  logic               vecValid,
  input  pi_pkg::piVectorT   vecData
);
  import pi_pkg::*;

  piLevelVecT levelOn, softReq, held;
  piLevelT aprChannel, mtrChannel, cycleLevel;
  logic sysActive, timeoutPulse, cycleBusy;
  logic [15:0] timeoutLimit;

  piRegs piRegs_i (.clk, .TIM, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
                   .pready, .pslverr, .held, .cycleLevel, .timeoutPulse, .levelOn,
                   .softReq, .sysActive, .aprChannel, .mtrChannel, .timeoutLimit);

  piArbiter piArbiter_i (.clk, .TIM, .ioReq, .aprInt, .mtrInt, .aprChannel, .mtrChannel,
                         .levelOn, .softReq, .sysActive, .intAck, .dismiss, .cycleBusy,
                         .intReq, .intLevel, .held);

  piVectorCycle piVectorCycle_i (.clk, .TIM, .intAck, .intReq, .intLevel, .aprInt, .mtrInt,
                                 .aprChannel, .mtrChannel, .timeoutLimit, .vecValid,
                                 .vecData, .vecReq, .vecLevel, .vecDone, .vecOut,
                                 .cycleBusy, .cycleLevel, .timeoutPulse);

endmodule

// File: logic/piRegs.sv
`timescale 1ns/100ps
`include "pi_defines.svh"

module piRegs (
  input  logic               clk,
  input  logic               TIM,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [4:0]         paddr,
  input  logic [31:0]        pwdata,
  output logic [31:0]        prdata,
  output logic               pready,
  output logic               pslverr,
  input  pi_pkg::piLevelVecT held,
  input  pi_pkg::piLevelT    cycleLevel,
  input  logic               timeoutPulse,
  output pi_pkg::piLevelVecT levelOn,
  output pi_pkg::piLevelVecT softReq,
  output logic               sysActive,
  output pi_pkg::piLevelT    aprChannel,
  output pi_pkg::piLevelT    mtrChannel,
  output logic [15:0]        timeoutLimit
);
  import pi_pkg::*;

  logic [`PI_LEVELS:0] enableReg;  // Top bit is the active bit
  piLevelVecT softReg;
  piLevelT aprChReg;
  piLevelT mtrChReg;
  logic [15:0] timeoutReg;
  logic timeoutFlag;
  logic mapped;
  logic wrEn;

  assign pready = 1'b1;
  assign mapped = (paddr == `PI_REG_ENABLE) || (paddr == `PI_REG_SOFTREQ) ||
                  (paddr == `PI_REG_CHANNEL) || (paddr == `PI_REG_TIMEOUT) ||
                  (paddr == `PI_REG_STATUS);
  assign pslverr = psel & penable & ~mapped;
  assign wrEn = psel & penable & pwrite & pready;

  always_ff @(posedge clk or posedge TIM) begin
    if (TIM) begin
      enableReg <= '0;
      softReg <= '0;
      aprChReg <= '0;
      mtrChReg <= '0;
      timeoutReg <= `PI_TIMEOUT_RST;
    end else if (wrEn) begin
      case (paddr)
        `PI_REG_ENABLE: enableReg <= pwdata[`PI_LEVELS:0];
        `PI_REG_SOFTREQ: softReg <= pwdata[`PI_LEVELS-1:0];
        `PI_REG_CHANNEL: begin
          aprChReg <= pwdata[2:0];
          mtrChReg <= pwdata[6:4];
        end
        `PI_REG_TIMEOUT: timeoutReg <= pwdata[15:0];
        default: ;
      endcase
    end
  end

  // Sticky flag, a new timeout beats a clear in the same cycle
  always_ff @(posedge clk or posedge TIM) begin
    if (TIM) begin
      timeoutFlag <= 1'b0;
    end else if (timeoutPulse) begin
      timeoutFlag <= 1'b1;
    end else if (wrEn && paddr == `PI_REG_STATUS && pwdata[16]) begin
      timeoutFlag <= 1'b0;
    end
  end

  always_comb begin
    prdata = '0;
    case (paddr)
      `PI_REG_ENABLE: prdata[`PI_LEVELS:0] = enableReg;
      `PI_REG_SOFTREQ: prdata[`PI_LEVELS-1:0] = softReg;
      `PI_REG_CHANNEL: prdata[6:0] = {mtrChReg, 1'b0, aprChReg};
      `PI_REG_TIMEOUT: prdata[15:0] = timeoutReg;
      `PI_REG_STATUS: prdata = {15'b0, timeoutFlag, 5'b0, cycleLevel, 1'b0, held};
      default: prdata = '0;
    endcase
  end

  assign levelOn = enableReg[`PI_LEVELS-1:0];
  assign sysActive = enableReg[`PI_LEVELS];
  assign softReq = softReg;
  assign aprChannel = aprChReg;
  assign mtrChannel = mtrChReg;
  assign timeoutLimit = timeoutReg;

endmodule

// File: logic/piVectorCycle.sv
`timescale 1ns/100ps
`include "pi_defines.svh"

module piVectorCycle (
  input  logic             clk,
  input  logic             TIM,
  input  logic             intAck,
  input  logic             intReq,
  input  pi_pkg::piLevelT  intLevel,
  input  logic             aprInt,
  input  logic             mtrInt,
  input  pi_pkg::piLevelT  aprChannel,
  input  pi_pkg::piLevelT  mtrChannel,
  input  logic [15:0]      timeoutLimit,
  input  logic             vecValid,
  input  pi_pkg::piVectorT vecData,
  output logic             vecReq,
  output pi_pkg::piLevelT  vecLevel,
  output logic             vecDone,
  output pi_pkg::piVectorT vecOut,
  output logic             cycleBusy,
  output pi_pkg::piLevelT  cycleLevel,
  output logic             timeoutPulse
);
  import pi_pkg::*;

  typedef enum logic [1:0] {Idle, BusWait, Done} stateT;

  stateT state;
  piLevelT levelReg;
  piVectorT vecReg;
  logic [15:0] waitCnt;
  logic ack;
  logic aprOwns;
  logic mtrOwns;
  logic timedOut;

  assign ack = intReq & intAck;
  assign aprOwns = aprInt && (aprChannel != '0) && (aprChannel == intLevel);
  assign mtrOwns = mtrInt && (mtrChannel != '0) && (mtrChannel == intLevel);
  assign timedOut = (state == BusWait) && !vecValid && (waitCnt >= timeoutLimit);

  always_ff @(posedge clk or posedge TIM) begin
    if (TIM) begin
      state <= Idle;
      waitCnt <= '0;
      timeoutPulse <= 1'b0;
    end else begin
      timeoutPulse <= timedOut;
      case (state)
        Idle: begin
          waitCnt <= '0;
          if (ack) state <= (aprOwns || mtrOwns) ? Done : BusWait;
        end
        BusWait: begin
          if (vecValid || timedOut) state <= Done;
          else waitCnt <= waitCnt + 16'd1;
        end
        default: state <= Idle;  // Done lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == Idle && ack) begin
      levelReg <= intLevel;
      vecReg <= aprOwns ? `PI_APR_VECTOR : `PI_MTR_VECTOR;  // Processor status first
    end else if (state == BusWait && vecValid) begin
      vecReg <= vecData;
    end else if (timedOut) begin
      vecReg <= `PI_VEC_W'(0);
    end
  end

  assign vecReq = (state == BusWait);
  assign vecLevel = levelReg;
  assign vecDone = (state == Done);
  assign vecOut = vecReg;
  assign cycleBusy = (state != Idle);
  assign cycleLevel = cycleBusy ? levelReg : '0;

endmodule

// File: logic/pi_defines.svh
`ifndef PI_DEFINES_SVH
`define PI_DEFINES_SVH

`define PI_LEVELS 7
`define PI_VEC_W 16

// APB register offsets
`define PI_REG_ENABLE 5'h00
`define PI_REG_SOFTREQ 5'h04
`define PI_REG_CHANNEL 5'h08
`define PI_REG_TIMEOUT 5'h0C
`define PI_REG_STATUS 5'h10

`define PI_APR_VECTOR 16'h0040
`define PI_MTR_VECTOR 16'h0050
`define PI_TIMEOUT_RST 16'd32

`endif

// File: logic/pi_pkg.sv
package pi_pkg;

  typedef logic [2:0] piLevelT;     // 0 is none, 1 ranks highest
  typedef logic [6:0] piLevelVecT;  // Bit 0 is level 1
  typedef logic [15:0] piVectorT;

  // One-hot bit for a level, empty for level 0
  function automatic piLevelVecT levelBit(piLevelT lvl);
    piLevelVecT v;
    v = '0;
    if (lvl != '0) v[lvl - 1] = 1'b1;
    return v;
  endfunction

  // Lowest-numbered set level, 0 when the vector is empty
  function automatic piLevelT lowestLevel(piLevelVecT v);
    piLevelT lvl;
    lvl = '0;
    for (int i = $bits(piLevelVecT) - 1; i >= 0; i--) begin
      if (v[i]) lvl = piLevelT'(i + 1);
    end
    return lvl;
  endfunction

endpackage

// File: piCtl.f
+incdir+logic
logic/pi_pkg.sv
logic/piRegs.sv
logic/piArbiter.sv
logic/piVectorCycle.sv
logic/piCtl.sv
tests/piCtl_props.sv
tests/piCtl_tb.sv

// File: tests/piCtl_props.sv
`timescale 1ns/100ps

module piCtl_props (
  input logic            clk,
  input logic            TIM,
  input logic            intReq,
  input logic            intAck,
  input pi_pkg::piLevelT intLevel,
  input logic            cycleBusy,
  input logic            vecReq,
  input pi_pkg::piLevelT vecLevel,
  input logic            vecValid,
  input logic            vecDone
);
  int failCount = 0;

  levelStable: assert property (@(posedge clk) disable iff (TIM)
                                intReq |=> (!intReq || $stable(intLevel)))
    else begin
      failCount++;
      $error("intLevel changed while intReq was high");
    end

  // Offer withdrawn once taken
  ackDrop: assert property (@(posedge clk) disable iff (TIM)
                            intReq && intAck |=> !intReq)
    else begin
      failCount++;
      $error("intReq still high after an acknowledge");
    end

  busyQuiet: assert property (@(posedge clk) disable iff (TIM)
                              cycleBusy |-> !intReq)
    else begin
      failCount++;
      $error("intReq high during an interrupt cycle");
    end

  donePulse: assert property (@(posedge clk) disable iff (TIM)
                              vecDone |=> !vecDone)
    else begin
      failCount++;
      $error("vecDone longer than one cycle");
    end

  vecHold: assert property (@(posedge clk) disable iff (TIM)
                            vecReq && !vecValid |=> (vecReq || vecDone) && $stable(vecLevel))
    else begin
      failCount++;
      $error("vecReq or vecLevel dropped before vecValid");
    end

endmodule

bind piCtl piCtl_props piCtl_props_i (.clk, .TIM, .intReq, .intAck, .intLevel, .cycleBusy,
                                      .vecReq, .vecLevel, .vecValid, .vecDone);

// File: tests/piCtl_tb.sv
`timescale 1ns/100ps
`include "pi_defines.svh"

module piCtl_tb;
  import pi_pkg::*;

  logic clk, TIM, pready, pslverr, intReq, vecDone, vecReq, vecValid;
  logic psel = 1'b0, penable = 1'b0, pwrite = 1'b0;
  logic aprInt = 1'b0, mtrInt = 1'b0, intAck = 1'b0, dismiss = 1'b0;
  logic [4:0] paddr = '0;
  logic [31:0] pwdata = '0, prdata, rd;
  piLevelVecT ioReq = '0;
  piLevelT intLevel, vecLevel, lvl;
  piVectorT vecOut, vecData;
  piLevelT silentLevel = '0;  // Responder never answers this level

  piCtl piCtl_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abortRun();
    $display("** FAIL **");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      abortRun();
    end
  endtask

  // Mapped offsets are word aligned, 0x00 to 0x10
  function automatic logic offsetUnmapped(input logic [4:0] addr);
    return (addr > `PI_REG_STATUS) || (addr[1:0] != 2'b00);
  endfunction

  task automatic apbWrite(input logic [4:0] addr, input logic [31:0] data);
    psel = 1'b1;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge clk);
    #1 penable = 1'b1;
    #1 checkValue("pready", pready, 1);
    checkValue("pslverr", pslverr, offsetUnmapped(addr));
    @(posedge clk);  // Write lands on this edge
    #1 psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apbRead(input logic [4:0] addr, output logic [31:0] data);
    psel = 1'b1;
    paddr = addr;
    @(posedge clk);
    #1 penable = 1'b1;
    #1 data = prdata;
    checkValue("pready", pready, 1);
    checkValue("pslverr", pslverr, offsetUnmapped(addr));
    @(posedge clk);
    #1 psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic waitFor(input bit forDone);
    int n;
    n = 0;
    while (!(forDone ? vecDone : intReq)) begin
      if (n == 200) begin
        $display("Timed out at %0t waiting for %s", $time, forDone ? "vecDone" : "intReq");
        abortRun();
      end
      @(posedge clk);
      #1 n++;
    end
  endtask

  // Acknowledge the offered level and collect its vector
  task automatic serveLevel(input piLevelT level, input piVectorT expVec, input bit fromSource);
    waitFor(1'b0);
    checkValue("intLevel", intLevel, level);
    intAck = 1'b1;
    @(posedge clk);
    #1 intAck = 1'b0;
    checkValue("intReq", intReq, 0);
    if (fromSource) begin
      checkValue("vecDone", vecDone, 1);
      checkValue("vecReq", vecReq, 0);
    end else begin
      checkValue("vecLevel", vecLevel, level);
      waitFor(1'b1);
    end
    checkValue("vecOut", vecOut, expVec);
  endtask

  task automatic expectQuiet(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1 checkValue("intReq", intReq, 0);
    end
  endtask

  task automatic dismissTop();
    @(posedge clk);
    #1 dismiss = 1'b1;
    @(posedge clk);
    #1 dismiss = 1'b0;
  endtask

  // Vector bus device, answers level x 0x100 after a random delay
  initial begin
    vecValid = 1'b0;
    vecData = '0;
    forever begin
      @(posedge clk);
      #1;
      if (vecValid || !vecReq || vecLevel == silentLevel) vecValid = 1'b0;
      else if ($urandom_range(1, 0) == 1) begin
        vecValid = 1'b1;
        vecData = piVectorT'(vecLevel) * 16'h0100;
      end
    end
  end

  always @(posedge clk) begin
    if (piCtl_i.piCtl_props_i.failCount != 0) begin
      $display("A handshake assertion failed at %0t", $time);
      abortRun();
    end
  end

  initial begin
    void'($urandom(39));
    TIM = 1'b1;
    repeat (5) @(posedge clk);
    #1 TIM = 1'b0;
    apbRead(`PI_REG_TIMEOUT, rd);
    checkValue("TIMEOUT", rd, `PI_TIMEOUT_RST);
    apbRead(5'h14, rd);  // Unmapped offset
    apbWrite(`PI_REG_ENABLE, 32'hFF);

    ioReq = 7'b0110000;  // Levels 5 and 6
    @(posedge clk);
    #1 checkValue("intReq", intReq, 0);
    @(posedge clk);
    #1 checkValue("intReq", intReq, 1);
    serveLevel(3'd5, 16'h0500, 1'b0);
    expectQuiet(4);  // 6 ranks below held 5
    ioReq = 7'b0110010;
    serveLevel(3'd2, 16'h0200, 1'b0);
    apbRead(`PI_REG_STATUS, rd);
    checkValue("STATUS", rd, 32'h12);
    ioReq = 7'b0100000;
    dismissTop();
    apbRead(`PI_REG_STATUS, rd);
    checkValue("STATUS", rd, 32'h10);
    dismissTop();
    serveLevel(3'd6, 16'h0600, 1'b0);
    ioReq = '0;
    dismissTop();

    apbWrite(`PI_REG_ENABLE, 32'hFB);  // Level 3 off
    ioReq = 7'b0000100;
    expectQuiet(4);
    apbWrite(`PI_REG_SOFTREQ, 32'h04);
    serveLevel(3'd3, 16'h0300, 1'b0);
    ioReq = '0;
    apbWrite(`PI_REG_SOFTREQ, 32'h00);
    dismissTop();
    apbWrite(`PI_REG_ENABLE, 32'h7F);
    apbWrite(`PI_REG_SOFTREQ, 32'h01);
    expectQuiet(4);
    apbWrite(`PI_REG_SOFTREQ, 32'h00);
    apbWrite(`PI_REG_ENABLE, 32'hFF);

    // Processor status on channel 4, meter on channel 2
    apbWrite(`PI_REG_CHANNEL, 32'h24);
    aprInt = 1'b1;
    serveLevel(3'd4, `PI_APR_VECTOR, 1'b1);
    aprInt = 1'b0;
    dismissTop();
    mtrInt = 1'b1;
    serveLevel(3'd2, `PI_MTR_VECTOR, 1'b1);
    mtrInt = 1'b0;
    dismissTop();

    for (int i = 0; i < 6; i++) begin
      lvl = piLevelT'($urandom_range(7, 1));
      ioReq = 7'b1 << (lvl - 1);
      serveLevel(lvl, piVectorT'(lvl) * 16'h0100, 1'b0);
      ioReq = '0;
      dismissTop();
    end

    // Level 1 arrives while level 4 is offered
    ioReq = 7'b0001000;
    waitFor(1'b0);
    ioReq = 7'b0001001;
    repeat (3) @(posedge clk);
    #1 serveLevel(3'd4, 16'h0400, 1'b0);
    ioReq = 7'b0000001;
    serveLevel(3'd1, 16'h0100, 1'b0);
    ioReq = '0;
    dismissTop();
    dismissTop();

    apbWrite(`PI_REG_TIMEOUT, 32'd8);
    silentLevel = 3'd7;
    ioReq = 7'b1000000;
    serveLevel(3'd7, 16'h0000, 1'b0);
    apbRead(`PI_REG_STATUS, rd);
    checkValue("STATUS", rd, 32'h10040);
    apbWrite(`PI_REG_STATUS, 32'h10000);
    apbRead(`PI_REG_STATUS, rd);
    checkValue("STATUS", rd, 32'h40);
    ioReq = '0;
    dismissTop();

    repeat (2) @(posedge clk);
    if (piCtl_i.piCtl_props_i.failCount != 0) begin
      $display("Handshake assertions failed during the run");
      abortRun();
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule
